// File: hdl/id_ex_register.sv
/*
 * ID/EX pipeline register
 * Stage ready/valid from halt, kill and EX ready, with field-qualified loads
 */
`timescale 1ns/1ps

module id_ex_register import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  if_id_pipe_t if_id_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  dec_ctrl_t   dec_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       operand_c_i,
  input  logic        ex_ready_i,
  output logic        id_ready_o,
  output logic        id_valid_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  logic local_valid;
  logic transfer;

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////
  // Kill and halt both hide the instruction from EX
  assign local_valid = if_id_pipe_i.instr_valid && !ctrl_fsm_i.kill_id && !ctrl_fsm_i.halt_id;
  assign id_valid_o  = local_valid;

  // Kill always drains ID
  assign id_ready_o  = ctrl_fsm_i.kill_id || (ex_ready_i && !ctrl_fsm_i.halt_id);

  assign transfer    = id_valid_o && ex_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_pipe_o <= '0;
    end else if (transfer) begin
      id_ex_pipe_o.instr_valid  <= 1'b1;
      id_ex_pipe_o.pc           <= if_id_pipe_i.pc;
      id_ex_pipe_o.instr        <= if_id_pipe_i.instr;
      id_ex_pipe_o.illegal_insn <= dec_i.illegal;

      // Operands only when consumed
      if (dec_i.op_a_sel != OP_A_NONE) begin
        id_ex_pipe_o.operand_a <= operand_a_i;
      end
      if (dec_i.op_b_sel != OP_B_NONE) begin
        id_ex_pipe_o.operand_b <= operand_b_i;
      end
      if (dec_i.op_c_sel != OP_C_NONE) begin
        id_ex_pipe_o.operand_c <= operand_c_i;
      end

      id_ex_pipe_o.alu_en <= dec_i.alu_en;
      if (dec_i.alu_en) begin
        id_ex_pipe_o.alu_bch <= dec_i.alu_bch;
        id_ex_pipe_o.alu_jmp <= dec_i.alu_jmp;
        id_ex_pipe_o.alu_op  <= dec_i.alu_op;
      end

      id_ex_pipe_o.lsu_en <= dec_i.lsu_en;
      if (dec_i.lsu_en) begin
        id_ex_pipe_o.lsu_we   <= dec_i.lsu_we;
        id_ex_pipe_o.lsu_size <= dec_i.lsu_size;
        id_ex_pipe_o.lsu_sext <= dec_i.lsu_sext;
      end

      id_ex_pipe_o.rf_we <= dec_i.rf_we;
      if (dec_i.rf_we) begin
        id_ex_pipe_o.rf_waddr <= dec_i.rd;
      end
    end else if (ex_ready_i) begin
      // Bubble into EX
      id_ex_pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

// File: hdl/id_pipe_pkg.sv
/*
 * Decode stage pipeline definitions
 * Stage boundary structs, controller inputs, mux selects, ALU operator
 */
package id_pipe_pkg;
  import rv_isa_pkg::*;

  // ALU operator, including branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Forwarding sources for rs1/rs2
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;

  // JALR base source, only WB is forwarded
  typedef enum logic {SELJ_REGFILE, SELJ_FW_WB} jalr_fw_sel_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REG, OP_C_BCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {BCH_JAL, BCH_JALR, BCH_BCH, BCH_NONE} bch_jmp_sel_e;

  // Fetch to decode
  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // Bypass controls from the controller
  typedef struct packed {
    fw_sel_e      operand_a_fw_sel;
    fw_sel_e      operand_b_fw_sel;
    jalr_fw_sel_e jalr_fw_sel;
    logic         deassert_we;
  } ctrl_byp_t;

  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_fsm_t;

  // Decoder outputs shared by the datapath blocks
  typedef struct packed {
    logic         alu_en;
    logic         alu_bch;
    logic         alu_jmp;
    logic         alu_jmpr;
    alu_op_e      alu_op;
    logic         lsu_en;
    logic         lsu_we;
    logic [1:0]   lsu_size;
    logic         lsu_sext;
    logic         rf_we;
    reg_addr_t    rd;
    logic         illegal;
    op_a_sel_e    op_a_sel;
    op_b_sel_e    op_b_sel;
    op_c_sel_e    op_c_sel;
    imm_b_sel_e   imm_b_sel;
    bch_jmp_sel_e bch_jmp_sel;
  } dec_ctrl_t;

  // Decode to execute
  typedef struct packed {
    logic       instr_valid;
    word_t      pc;
    word_t      instr;
    logic       alu_en;
    logic       alu_bch;
    logic       alu_jmp;
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_sext;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    logic       illegal_insn;
  } id_ex_pipe_t;

endpackage

// File: hdl/id_stage.sv
/*
 * RV32I instruction decode stage
 * Decoder, immediate and target generation, forwarding and ID/EX register
 */
`timescale 1ns/1ps

module id_stage import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Fetch
  input  if_id_pipe_t if_id_pipe_i,
  // Controller
  input  ctrl_byp_t   ctrl_byp_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  // Register file read port and forwarding data
  output reg_addr_t   rf_raddr_o [2],
  output logic [1:0]  rf_re_o,
  input  word_t       rf_rdata_i [2],
  input  word_t       rf_wdata_ex_i,
  input  word_t       rf_wdata_wb_i,
  // Jump target to fetch
  output word_t       jmp_target_o,
  // Stage handshake
  input  logic        ex_ready_i,
  output logic        id_ready_o,
  output logic        id_valid_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  dec_ctrl_t dec;
  word_t     imm_b;
  word_t     bch_target;
  word_t     jalr_base;
  word_t     operand_a;
  word_t     operand_b;
  word_t     operand_c;

  // Source register addresses straight from the instruction
  assign rf_raddr_o[0] = if_id_pipe_i.instr[RS1_MSB:RS1_LSB];
  assign rf_raddr_o[1] = if_id_pipe_i.instr[RS2_MSB:RS2_LSB];

  // JALR reads rs1 for its base even though operand A is pc
  assign rf_re_o[0] = (dec.op_a_sel == OP_A_REG) || dec.alu_jmpr;
  assign rf_re_o[1] = (dec.op_b_sel == OP_B_REG) || (dec.op_c_sel == OP_C_REG);

  instr_decoder decoder_i (
    .instr_i       (if_id_pipe_i.instr),
    .deassert_we_i (ctrl_byp_i.deassert_we),
    .dec_o         (dec)
  );

  imm_target_gen imm_target_i (
    .instr_i      (if_id_pipe_i.instr),
    .pc_i         (if_id_pipe_i.pc),
    .dec_i        (dec),
    .jalr_base_i  (jalr_base),
    .imm_b_o      (imm_b),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  operand_mux operand_mux_i (
    .ctrl_byp_i    (ctrl_byp_i),
    .dec_i         (dec),
    .pc_i          (if_id_pipe_i.pc),
    .rf_rdata_i    (rf_rdata_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .imm_b_i       (imm_b),
    .bch_target_i  (bch_target),
    .jalr_base_o   (jalr_base),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c)
  );

  id_ex_register id_ex_reg_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_pipe_i (if_id_pipe_i),
    .ctrl_fsm_i   (ctrl_fsm_i),
    .dec_i        (dec),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .operand_c_i  (operand_c),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

// File: hdl/imm_target_gen.sv
/*
 * Immediate and target generator
 * Sign-extends the I/S/B/U/J immediates, picks the operand B immediate
 * and computes branch and jump targets
 */
`timescale 1ns/1ps

module imm_target_gen import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  dec_ctrl_t dec_i,
  input  word_t     jalr_base_i,
  output word_t     imm_b_o,
  output word_t     bch_target_o,
  output word_t     jmp_target_o
);

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_sb_type;
  word_t imm_u_type;
  word_t imm_uj_type;
  word_t jalr_sum;

  // Sign bit is always instr[31]
  assign imm_i_type  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type  = {instr_i[31:12], 12'b0};
  assign imm_uj_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

  // Operand B immediate
  always_comb begin
    case (dec_i.imm_b_sel)
      IMMB_S:      imm_b_o = imm_s_type;
      IMMB_U:      imm_b_o = imm_u_type;
      IMMB_PCINCR: imm_b_o = PC_INCR;
      default:     imm_b_o = imm_i_type;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////
  // Branch target goes to EX on operand C
  assign bch_target_o = pc_i + imm_sb_type;

  assign jalr_sum = jalr_base_i + imm_i_type;

  // Jumps resolve in ID
  always_comb begin
    case (dec_i.bch_jmp_sel)
      BCH_JALR: jmp_target_o = {jalr_sum[31:1], 1'b0};
      default:  jmp_target_o = pc_i + imm_uj_type;
    endcase
  end

endmodule

// File: hdl/instr_decoder.sv
/*
 * RV32I instruction decoder
 * Maps opcode, funct3 and funct7 onto unit enables, ALU operator,
 * operand and immediate selects, and flags illegal encodings
 */
`timescale 1ns/1ps

module instr_decoder import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  word_t     instr_i,
  input  logic      deassert_we_i,
  output dec_ctrl_t dec_o
);

  // Nothing enabled, no operand taken
  localparam dec_ctrl_t DEC_IDLE = '{
    alu_op:      ALU_ADD,
    op_a_sel:    OP_A_NONE,
    op_b_sel:    OP_B_NONE,
    op_c_sel:    OP_C_NONE,
    imm_b_sel:   IMMB_I,
    bch_jmp_sel: BCH_NONE,
    default:     '0
  };

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr_i[OPCODE_MSB:OPCODE_LSB]);
  assign funct3 = instr_i[FUNCT3_MSB:FUNCT3_LSB];
  assign funct7 = instr_i[FUNCT7_MSB:FUNCT7_LSB];

  always_comb begin
    dec_o    = DEC_IDLE;
    dec_o.rd = instr_i[RD_MSB:RD_LSB];

    case (opcode)
      //////////////////////////////////////////////////////////////////////
      // Register and immediate arithmetic
      //////////////////////////////////////////////////////////////////////
      OPC_OP: begin
        dec_o.alu_en   = 1'b1;
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = OP_A_REG;
        dec_o.op_b_sel = OP_B_REG;
        if (funct7 == 7'h00) begin
          case (funct3)
            3'b000:  dec_o.alu_op = ALU_ADD;
            3'b001:  dec_o.alu_op = ALU_SLL;
            3'b010:  dec_o.alu_op = ALU_SLT;
            3'b011:  dec_o.alu_op = ALU_SLTU;
            3'b100:  dec_o.alu_op = ALU_XOR;
            3'b101:  dec_o.alu_op = ALU_SRL;
            3'b110:  dec_o.alu_op = ALU_OR;
            default: dec_o.alu_op = ALU_AND;
          endcase
        end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
          dec_o.alu_op = ALU_SUB;
        end else if (funct7 == 7'h20 && funct3 == 3'b101) begin
          dec_o.alu_op = ALU_SRA;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      OPC_OPIMM: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_REG;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_I;
        case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            // Shift amount only, upper bits must be zero
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'h00);
          end
          default: begin
            // funct7 picks logical or arithmetic right shift
            dec_o.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            dec_o.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      // Upper immediates, ALU adds U immediate to zero or pc
      OPC_LUI, OPC_AUIPC: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_U;
      end

      //////////////////////////////////////////////////////////////////////
      // Control transfer
      //////////////////////////////////////////////////////////////////////
      // ALU computes the link address pc + 4
      OPC_JAL, OPC_JALR: begin
        dec_o.alu_en      = 1'b1;
        dec_o.alu_jmp     = 1'b1;
        dec_o.alu_jmpr    = (opcode == OPC_JALR);
        dec_o.rf_we       = 1'b1;
        dec_o.op_a_sel    = OP_A_PC;
        dec_o.op_b_sel    = OP_B_IMM;
        dec_o.imm_b_sel   = IMMB_PCINCR;
        dec_o.bch_jmp_sel = (opcode == OPC_JALR) ? BCH_JALR : BCH_JAL;
        dec_o.illegal     = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end

      // Compare rs1 with rs2, target travels as operand C
      OPC_BRANCH: begin
        dec_o.alu_en      = 1'b1;
        dec_o.alu_bch     = 1'b1;
        dec_o.op_a_sel    = OP_A_REG;
        dec_o.op_b_sel    = OP_B_REG;
        dec_o.op_c_sel    = OP_C_BCH;
        dec_o.bch_jmp_sel = BCH_BCH;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end

      //////////////////////////////////////////////////////////////////////
      // Memory access
      //////////////////////////////////////////////////////////////////////
      OPC_LOAD: begin
        dec_o.lsu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_REG;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_I;
        dec_o.lsu_size  = funct3[1:0];
        dec_o.lsu_sext  = !funct3[2];
        // No word access with zero extension, no doubleword
        dec_o.illegal   = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      OPC_STORE: begin
        dec_o.lsu_en    = 1'b1;
        dec_o.lsu_we    = 1'b1;
        dec_o.op_a_sel  = OP_A_REG;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.op_c_sel  = OP_C_REG;
        dec_o.imm_b_sel = IMMB_S;
        dec_o.lsu_size  = funct3[1:0];
        dec_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // Illegal encodings reach EX as a flag only
    if (dec_o.illegal) begin
      dec_o         = DEC_IDLE;
      dec_o.illegal = 1'b1;
    end

    // Controller suppresses side effects, illegal flag stays
    if (deassert_we_i) begin
      dec_o.rf_we  = 1'b0;
      dec_o.alu_en = 1'b0;
      dec_o.lsu_en = 1'b0;
    end
  end

endmodule

// File: hdl/operand_mux.sv
/*
 * Operand forwarding and selection
 * Chooses register file, EX or WB data for rs1/rs2 and builds operands A, B, C
 */
`timescale 1ns/1ps

module operand_mux import rv_isa_pkg::*, id_pipe_pkg::*; (
  input  ctrl_byp_t ctrl_byp_i,
  input  dec_ctrl_t dec_i,
  input  word_t     pc_i,
  input  word_t     rf_rdata_i [2],
  input  word_t     rf_wdata_ex_i,
  input  word_t     rf_wdata_wb_i,
  input  word_t     imm_b_i,
  input  word_t     bch_target_i,
  output word_t     jalr_base_o,
  output word_t     operand_a_o,
  output word_t     operand_b_o,
  output word_t     operand_c_o
);

  word_t operand_a_fw;
  word_t operand_b_fw;

  // Same forwarding mux for both source registers
  function automatic word_t fw_pick(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  assign operand_a_fw = fw_pick(ctrl_byp_i.operand_a_fw_sel, rf_rdata_i[0],
                                rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fw_pick(ctrl_byp_i.operand_b_fw_sel, rf_rdata_i[1],
                                rf_wdata_ex_i, rf_wdata_wb_i);

  // JALR base, EX result not forwarded here
  assign jalr_base_o = (ctrl_byp_i.jalr_fw_sel == SELJ_FW_WB) ? rf_wdata_wb_i : rf_rdata_i[0];

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = operand_a_fw;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_b_i : operand_b_fw;

  // Store data or branch target
  assign operand_c_o = (dec_i.op_c_sel == OP_C_BCH) ? bch_target_i : operand_b_fw;

endmodule

// File: hdl/rv_isa_pkg.sv
/*
 * RV32I encoding definitions
 * Word and register index types, kept major opcodes and field positions
 */
package rv_isa_pkg;

  // Data, address and instruction words
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes of the base integer set handled by decode
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OPIMM  = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6F
  } opcode_e;

  // Instruction field positions
  localparam int unsigned OPCODE_MSB = 6;
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned RD_MSB     = 11;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_MSB = 14;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_MSB    = 19;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_MSB    = 24;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_MSB = 31;
  localparam int unsigned FUNCT7_LSB = 25;

  // Link offset, no compressed instructions
  localparam word_t PC_INCR = 32'd4;

endpackage

// File: id_stage.f
hdl/rv_isa_pkg.sv
hdl/id_pipe_pkg.sv
hdl/instr_decoder.sv
hdl/imm_target_gen.sv
hdl/operand_mux.sv
hdl/id_ex_register.sv
hdl/id_stage.sv
sim/id_stage_chk.sv
sim/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module id_stage_tb -f id_stage.f -o id_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/id_stage_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

// File: sim/id_stage_chk.sv
/*
 * Bound checker for the decode stage
 * Reset values, back-pressure hold, bubble and ready/valid rules
 */
`timescale 1ns/1ps

module id_stage_chk import rv_isa_pkg::*, id_pipe_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input if_id_pipe_t if_id_pipe_i,
  input ctrl_fsm_t   ctrl_fsm_i,
  input logic        ex_ready_i,
  input logic        id_ready_o,
  input logic        id_valid_o,
  input id_ex_pipe_t id_ex_pipe_o
);

  // Failure count, read by the testbench
  int unsigned fail_cnt = 0;

  reset_values: assert property (@(posedge clk) !rst_n |-> id_ex_pipe_o == '0)
    else begin $error("ID/EX register not cleared during reset"); fail_cnt++; end

  // EX stalled, every field holds
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_pipe_o))
    else begin $error("ID/EX register changed while EX was not ready"); fail_cnt++; end

  bubble_on_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_ready_i && !id_valid_o) |=> !id_ex_pipe_o.instr_valid)
    else begin $error("no bubble after an edge without a valid instruction"); fail_cnt++; end

  valid_rule: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o == (if_id_pipe_i.instr_valid && !ctrl_fsm_i.kill_id && !ctrl_fsm_i.halt_id))
    else begin $error("id_valid_o does not follow valid, halt and kill"); fail_cnt++; end

  kill_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.kill_id |-> id_ready_o)
    else begin $error("id_ready_o low during a kill"); fail_cnt++; end

  stall_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_ready_i && !ctrl_fsm_i.kill_id) |-> !id_ready_o)
    else begin $error("id_ready_o high while EX was not ready"); fail_cnt++; end

endmodule

bind id_stage id_stage_chk chk_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .if_id_pipe_i (if_id_pipe_i),
  .ctrl_fsm_i   (ctrl_fsm_i),
  .ex_ready_i   (ex_ready_i),
  .id_ready_o   (id_ready_o),
  .id_valid_o   (id_valid_o),
  .id_ex_pipe_o (id_ex_pipe_o)
);

// File: sim/id_stage_tb.sv
/*
 * Testbench for the RV32I decode stage
 * Random instructions and controller inputs, reference model of ID/EX
 */
`timescale 1ns/1ps

module id_stage_tb import rv_isa_pkg::*, id_pipe_pkg::*; ();

  localparam int unsigned N_INSTR    = 1000;
  localparam int unsigned SEED       = 96255;
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned MAX_CYCLES = RST_CYCLES + 3000 + 100;

  logic        clk;
  logic        rst_n;
  if_id_pipe_t if_id;
  ctrl_byp_t   byp;
  ctrl_fsm_t   fsm;
  word_t       rdata [2];
  word_t       wdata_ex;
  word_t       wdata_wb;
  logic        ex_ready;
  reg_addr_t   raddr [2];
  logic [1:0]  rf_re;
  word_t       jmp_target;
  logic        id_ready;
  logic        id_valid;
  id_ex_pipe_t pipe;

  // Model state
  id_ex_pipe_t exp_pipe;
  word_t       exp_jmp;
  logic [1:0]  exp_re;
  logic        jmp_check;
  int unsigned model_errs;
  int unsigned cycles;
  int unsigned n_done;
  logic        advance;

  id_stage UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_pipe_i  (if_id),
    .ctrl_byp_i    (byp),
    .ctrl_fsm_i    (fsm),
    .rf_raddr_o    (raddr),
    .rf_re_o       (rf_re),
    .rf_rdata_i    (rdata),
    .rf_wdata_ex_i (wdata_ex),
    .rf_wdata_wb_i (wdata_wb),
    .jmp_target_o  (jmp_target),
    .ex_ready_i    (ex_ready),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .id_ex_pipe_o  (pipe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////
  // Nine kept opcodes plus one slot left as a raw random word
  function automatic word_t rand_instr();
    word_t       w;
    int unsigned k;
    w = $urandom;
    k = $urandom % 10;
    case (k)
      0: w[6:0] = 7'h33;
      1: w[6:0] = 7'h13;
      2: w[6:0] = 7'h37;
      3: w[6:0] = 7'h17;
      4: w[6:0] = 7'h6F;
      5: w[6:0] = 7'h67;
      6: w[6:0] = 7'h63;
      7: w[6:0] = 7'h03;
      8: w[6:0] = 7'h23;
      default: ;
    endcase
    // Steer funct7 towards the legal values for OP and OP-IMM
    if (k < 2) begin
      case ($urandom % 3)
        0:       w[31:25] = 7'h00;
        1:       w[31:25] = 7'h20;
        default: ;
      endcase
    end
    return w;
  endfunction

  task automatic drive_inputs(input logic new_instr);
    if (new_instr) begin
      if_id.instr_valid = ($urandom % 8) != 0;
      if_id.pc          = $urandom & 32'hFFFF_FFFC;
      if_id.instr       = rand_instr();
    end
    byp.operand_a_fw_sel = fw_sel_e'($urandom % 3);
    byp.operand_b_fw_sel = fw_sel_e'($urandom % 3);
    byp.jalr_fw_sel      = jalr_fw_sel_e'($urandom % 2);
    byp.deassert_we      = ($urandom % 8) == 0;
    fsm.halt_id          = ($urandom % 8) == 0;
    fsm.kill_id          = ($urandom % 8) == 0;
    ex_ready             = ($urandom % 4) != 0;
    rdata[0]             = $urandom;
    rdata[1]             = $urandom;
    wdata_ex             = $urandom;
    wdata_wb             = $urandom;
  endtask

  function automatic word_t fwd(fw_sel_e sel, word_t rf);
    if (sel == SEL_FW_EX) return wdata_ex;
    if (sel == SEL_FW_WB) return wdata_wb;
    return rf;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////
  task automatic predict();
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      c;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_sb;
    word_t      imm_u;
    word_t      imm_j;
    word_t      base;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       legal;
    logic       use_a;
    logic       use_b;
    logic       use_c;
    logic       alu;
    logic       bch;
    logic       jmp;
    logic       lsu;
    logic       lsu_we;
    logic       sext;
    logic       wr;
    logic       re1;
    logic       re2;
    alu_op_e    op;
    ins    = if_id.instr;
    opc    = ins[6:0];
    f3     = ins[14:12];
    f7     = ins[31:25];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_sb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u  = {ins[31:12], 12'h000};
    imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    legal  = 1'b1;
    {use_a, use_b, use_c, alu, bch, jmp, lsu, lsu_we, sext, wr, re1, re2} = '0;
    op     = ALU_ADD;
    a      = fwd(byp.operand_a_fw_sel, rdata[0]);
    b      = fwd(byp.operand_b_fw_sel, rdata[1]);
    c      = b;
    case (opc)
      7'h33, 7'h13: begin
        {use_a, use_b, alu, wr, re1} = '1;
        re2 = (opc == 7'h33);
        if (opc == 7'h13 && f3 != 3'd1 && f3 != 3'd5) begin
          b = imm_i;
        end else if (opc == 7'h13) begin
          b     = imm_i;
          legal = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
        end else begin
          legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        case (f3)
          3'd0: op = (opc == 7'h33 && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
          3'd1: op = ALU_SLL;
          3'd2: op = ALU_SLT;
          3'd3: op = ALU_SLTU;
          3'd4: op = ALU_XOR;
          3'd5: op = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
          3'd6: op = ALU_OR;
          default: op = ALU_AND;
        endcase
      end
      7'h37, 7'h17: begin
        {use_a, use_b, alu, wr} = '1;
        a = (opc == 7'h37) ? 32'h0 : if_id.pc;
        b = imm_u;
      end
      7'h6F, 7'h67: begin
        {use_a, use_b, alu, jmp, wr} = '1;
        // JALR base comes from rs1
        re1   = (opc == 7'h67);
        a     = if_id.pc;
        b     = 32'd4;
        legal = (opc == 7'h6F) || (f3 == 3'd0);
      end
      7'h63: begin
        {use_a, use_b, use_c, alu, bch, re1, re2} = '1;
        c     = if_id.pc + imm_sb;
        legal = (f3 != 3'd2) && (f3 != 3'd3);
        case (f3)
          3'd0: op = ALU_EQ;
          3'd1: op = ALU_NE;
          3'd4: op = ALU_LT;
          3'd5: op = ALU_GE;
          3'd6: op = ALU_LTU;
          default: op = ALU_GEU;
        endcase
      end
      7'h03: begin
        {use_a, use_b, lsu, wr, re1} = '1;
        b     = imm_i;
        sext  = !f3[2];
        legal = (f3[1:0] != 2'b11) && (f3 != 3'd6);
      end
      7'h23: begin
        {use_a, use_b, use_c, lsu, lsu_we, re1, re2} = '1;
        b     = imm_s;
        legal = !f3[2] && (f3[1:0] != 2'b11);
      end
      default: legal = 1'b0;
    endcase

    // Jump target is visible in the same cycle
    base      = byp.jalr_fw_sel == SELJ_FW_WB ? wdata_wb : rdata[0];
    jmp_check = legal && (opc == 7'h6F || opc == 7'h67);
    exp_jmp   = (opc == 7'h67) ? ((base + imm_i) & 32'hFFFF_FFFE) : if_id.pc + imm_j;

    // Illegal encodings read no registers
    exp_re = legal ? {re2, re1} : 2'b00;

    if (!legal || byp.deassert_we) begin
      {alu, lsu, wr} = '0;
    end
    if (if_id.instr_valid && !fsm.kill_id && !fsm.halt_id && ex_ready) begin
      exp_pipe.instr_valid  = 1'b1;
      exp_pipe.pc           = if_id.pc;
      exp_pipe.instr        = ins;
      exp_pipe.illegal_insn = !legal;
      // Operands of an illegal instruction are not consumed
      if (legal && use_a) exp_pipe.operand_a = a;
      if (legal && use_b) exp_pipe.operand_b = b;
      if (legal && use_c) exp_pipe.operand_c = c;
      exp_pipe.alu_en = alu;
      if (alu) begin
        exp_pipe.alu_bch = bch;
        exp_pipe.alu_jmp = jmp;
        exp_pipe.alu_op  = op;
      end
      exp_pipe.lsu_en = lsu;
      if (lsu) begin
        exp_pipe.lsu_we   = lsu_we;
        exp_pipe.lsu_size = f3[1:0];
        exp_pipe.lsu_sext = sext;
      end
      exp_pipe.rf_we = wr;
      if (wr) exp_pipe.rf_waddr = ins[11:7];
    end else if (ex_ready) begin
      exp_pipe.instr_valid = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("** Error at %0t: %s is %h, expected %h", $realtime, what, got, want);
      model_errs++;
    end
  endtask

  task automatic check_comb();
    check_value("id_valid_o", 32'(id_valid),
                32'(if_id.instr_valid && !fsm.kill_id && !fsm.halt_id));
    check_value("id_ready_o", 32'(id_ready),
                32'(fsm.kill_id || (ex_ready && !fsm.halt_id)));
    check_value("rf_raddr_o[0]", 32'(raddr[0]), 32'(if_id.instr[19:15]));
    check_value("rf_raddr_o[1]", 32'(raddr[1]), 32'(if_id.instr[24:20]));
    check_value("rf_re_o", 32'(rf_re), 32'(exp_re));
    if (jmp_check) check_value("jmp_target_o", jmp_target, exp_jmp);
  endtask

  task automatic check_pipe();
    check_value("instr_valid", 32'(pipe.instr_valid), 32'(exp_pipe.instr_valid));
    check_value("pc", pipe.pc, exp_pipe.pc);
    check_value("instr", pipe.instr, exp_pipe.instr);
    check_value("illegal_insn", 32'(pipe.illegal_insn), 32'(exp_pipe.illegal_insn));
    check_value("alu_en", 32'(pipe.alu_en), 32'(exp_pipe.alu_en));
    check_value("alu_bch", 32'(pipe.alu_bch), 32'(exp_pipe.alu_bch));
    check_value("alu_jmp", 32'(pipe.alu_jmp), 32'(exp_pipe.alu_jmp));
    check_value("alu_op", 32'(pipe.alu_op), 32'(exp_pipe.alu_op));
    check_value("operand_a", pipe.operand_a, exp_pipe.operand_a);
    check_value("operand_b", pipe.operand_b, exp_pipe.operand_b);
    check_value("operand_c", pipe.operand_c, exp_pipe.operand_c);
    check_value("lsu fields", 32'({pipe.lsu_en, pipe.lsu_we, pipe.lsu_size, pipe.lsu_sext}),
                32'({exp_pipe.lsu_en, exp_pipe.lsu_we, exp_pipe.lsu_size, exp_pipe.lsu_sext}));
    check_value("rf_we", 32'(pipe.rf_we), 32'(exp_pipe.rf_we));
    check_value("rf_waddr", 32'(pipe.rf_waddr), 32'(exp_pipe.rf_waddr));
  endtask

  task automatic report_and_finish();
    $display("Checks done: %0d instructions, %0d model errors, %0d assertion errors",
             n_done, model_errs, UUT.chk_i.fail_cnt);
    if (model_errs == 0 && UUT.chk_i.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: only %0d of %0d instructions done after %0d cycles",
               n_done, N_INSTR, cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    if_id      = '0;
    byp        = '0;
    fsm        = '0;
    rdata[0]   = '0;
    rdata[1]   = '0;
    wdata_ex   = '0;
    wdata_wb   = '0;
    ex_ready   = 1'b0;
    exp_pipe   = '0;
    exp_jmp    = '0;
    exp_re     = '0;
    jmp_check  = 1'b0;
    model_errs = 0;
    cycles     = 0;
    n_done     = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #0.5 check_pipe();
    #0.5 rst_n = 1'b1;
    drive_inputs(1'b1);
    while (n_done < N_INSTR) begin
      @(negedge clk);
      predict();
      check_comb();
      // Fetch moves on when ID takes the instruction or has none
      advance = id_ready || !if_id.instr_valid;
      if (advance && if_id.instr_valid) n_done++;
      @(posedge clk);
      #0.5 check_pipe();
      #0.5 drive_inputs(advance);
    end
    repeat (2) @(posedge clk);
    report_and_finish();
  end

endmodule
